//--- dispatch_pkg.sv
/*
    Sizes and uop-class bit positions of the two-slot vector dispatch stage.
*/
package dispatch_pkg;

    // Issue width is fixed at two slots
    localparam int num_dp_uop  = 2;
    localparam int num_rd_port = 4;

    localparam int vlen                = 64;
    localparam int regfile_index_width = 5;
    // funct6 and funct3 side by side
    localparam int funct_width         = 9;

    localparam int rob_depth       = 8;
    localparam int rob_depth_width = 3;

    // One bit per source that the uop reads
    localparam int uop_class_width = 3;
    localparam int class_vd_bit    = 2;
    localparam int class_vs2_bit   = 1;
    localparam int class_vs1_bit   = 0;

    // Read ports are handed out in this source order
    localparam int port_order [3] = '{class_vs2_bit, class_vs1_bit, class_vd_bit};

endpackage

//--- dispatch_raw_rob.sv
/*
    RAW check of one uop's sources against every ROB entry.
    The youngest writer of a source decides: still busy means a hazard,
    done means the source is bypassed from that entry.
*/
`timescale 1ns/100ps

module dispatch_raw_rob (
    input  logic [dispatch_pkg::uop_class_width-1:0]                        uop_class,
    input  logic [dispatch_pkg::regfile_index_width-1:0]                    uop_vs1_index,
    input  logic [dispatch_pkg::regfile_index_width-1:0]                    uop_vs2_index,
    input  logic [dispatch_pkg::regfile_index_width-1:0]                    uop_vd_index,
    input  logic [dispatch_pkg::rob_depth_width-1:0]                        rob_head_index,
    input  logic [dispatch_pkg::rob_depth-1:0]                              rob_entry_valid,
    input  logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::regfile_index_width-1:0]
                                                                            rob_entry_w_index,
    input  logic [dispatch_pkg::rob_depth-1:0]                              rob_entry_done,
    output logic                                                            raw_hazard,
    output logic [2:0]                                                      byp_hit,
    output logic [2:0][dispatch_pkg::rob_depth_width-1:0]                   byp_entry
);

    logic [2:0][dispatch_pkg::regfile_index_width-1:0] src_index;
    logic [2:0]                                        src_match;
    logic [2:0]                                        src_pending;

    // Sources are indexed by their class bit
    assign src_index[dispatch_pkg::class_vd_bit]  = uop_vd_index;
    assign src_index[dispatch_pkg::class_vs2_bit] = uop_vs2_index;
    assign src_index[dispatch_pkg::class_vs1_bit] = uop_vs1_index;

    always_comb begin
        logic [dispatch_pkg::rob_depth_width-1:0] entry;
        src_match = '0;
        byp_entry = '0;
        // Walk from head to tail, so a later match is a younger writer
        for (int k = 0; k < dispatch_pkg::rob_depth; k++) begin
            entry = rob_head_index + k[dispatch_pkg::rob_depth_width-1:0];
            for (int s = 0; s < 3; s++) begin
                if (rob_entry_valid[entry] && rob_entry_w_index[entry] == src_index[s]) begin
                    src_match[s] = 1'b1;
                    byp_entry[s] = entry;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            byp_hit[s]     = uop_class[s] && src_match[s] && rob_entry_done[byp_entry[s]];
            src_pending[s] = uop_class[s] && src_match[s] && !rob_entry_done[byp_entry[s]];
        end
    end

    assign raw_hazard = |src_pending;

endmodule

//--- dispatch_bypass.sv
/*
    Operand select for one uop. Each source comes from the ROB entry chosen
    by the RAW check, or else from the VRF data routed to this slot.
*/
`timescale 1ns/100ps

module dispatch_bypass (
    input  logic [2:0]                                               byp_hit,
    input  logic [2:0][dispatch_pkg::rob_depth_width-1:0]            byp_entry,
    input  logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::vlen-1:0] rob_entry_data,
    input  logic [dispatch_pkg::vlen-1:0]                            port_data_vs1,
    input  logic [dispatch_pkg::vlen-1:0]                            port_data_vs2,
    input  logic [dispatch_pkg::vlen-1:0]                            port_data_vd,
    output logic [dispatch_pkg::vlen-1:0]                            opr_vs1,
    output logic [dispatch_pkg::vlen-1:0]                            opr_vs2,
    output logic [dispatch_pkg::vlen-1:0]                            opr_vd
);

    assign opr_vs1 = byp_hit[dispatch_pkg::class_vs1_bit] ?
                     rob_entry_data[byp_entry[dispatch_pkg::class_vs1_bit]] : port_data_vs1;
    assign opr_vs2 = byp_hit[dispatch_pkg::class_vs2_bit] ?
                     rob_entry_data[byp_entry[dispatch_pkg::class_vs2_bit]] : port_data_vs2;
    assign opr_vd  = byp_hit[dispatch_pkg::class_vd_bit] ?
                     rob_entry_data[byp_entry[dispatch_pkg::class_vd_bit]] : port_data_vd;

endmodule

//--- dispatch_raw_uop.sv
/*
    RAW check between the two slots. Slot 1 is flagged when a source it
    reads is the vd that a valid slot 0 writes in the same cycle.
*/
`timescale 1ns/100ps

module dispatch_raw_uop (
    input  logic                                         uop0_valid,
    input  logic                                         uop0_vd_write,
    input  logic [dispatch_pkg::regfile_index_width-1:0] uop0_vd_index,
    input  logic [dispatch_pkg::uop_class_width-1:0]     uop1_class,
    input  logic [dispatch_pkg::regfile_index_width-1:0] uop1_vs1_index,
    input  logic [dispatch_pkg::regfile_index_width-1:0] uop1_vs2_index,
    input  logic [dispatch_pkg::regfile_index_width-1:0] uop1_vd_index,
    output logic                                         raw_hazard
);

    logic vs1_hit;
    logic vs2_hit;
    logic vd_hit;

    assign vs1_hit = uop1_class[dispatch_pkg::class_vs1_bit] && uop1_vs1_index == uop0_vd_index;
    assign vs2_hit = uop1_class[dispatch_pkg::class_vs2_bit] && uop1_vs2_index == uop0_vd_index;
    assign vd_hit  = uop1_class[dispatch_pkg::class_vd_bit]  && uop1_vd_index  == uop0_vd_index;

    assign raw_hazard = uop0_valid && uop0_vd_write && (vs1_hit || vs2_hit || vd_hit);

endmodule

//--- dispatch_read_port.sv
/*
    VRF read-port allocation for both slots. Slot 0 fills ports from 0 in
    the order vs2, vs1, vd and slot 1 carries on from the next free port.
    More than num_rd_port sources in total is a structural hazard, and then
    slot 1 gets no ports. VRF data comes back the same cycle and is routed
    to the source that asked for it.
*/
`timescale 1ns/100ps

module dispatch_read_port (
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::uop_class_width-1:0]     uop_class,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs1_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs2_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vd_index,
    input  logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::vlen-1:0]               vrf_rd_data,
    output logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::regfile_index_width-1:0] vrf_rd_index,
    output logic                                                                        arch_hazard,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                port_data_vs1,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                port_data_vs2,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                port_data_vd
);

    logic [dispatch_pkg::num_dp_uop-1:0][2:0][dispatch_pkg::regfile_index_width-1:0] src_index;
    logic [dispatch_pkg::num_dp_uop-1:0][2:0][dispatch_pkg::vlen-1:0]                src_data;
    logic [dispatch_pkg::num_dp_uop-1:0][1:0]                                        src_count;
    logic [2:0]                                                                      total_count;

    always_comb begin
        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            src_index[i][dispatch_pkg::class_vs1_bit] = uop_vs1_index[i];
            src_index[i][dispatch_pkg::class_vs2_bit] = uop_vs2_index[i];
            src_index[i][dispatch_pkg::class_vd_bit]  = uop_vd_index[i];
            src_count[i] = uop_class[i][0] + uop_class[i][1] + uop_class[i][2];
        end
    end

    assign total_count = src_count[0] + src_count[1];
    assign arch_hazard = total_count > dispatch_pkg::num_rd_port;

    always_comb begin
        int port;
        int src;
        port         = 0;
        vrf_rd_index = '0;
        src_data     = '0;
        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            // Slot 1 reads nothing on a structural hazard
            if (i == 0 || !arch_hazard) begin
                for (int k = 0; k < 3; k++) begin
                    src = dispatch_pkg::port_order[k];
                    if (uop_class[i][src]) begin
                        vrf_rd_index[port] = src_index[i][src];
                        src_data[i][src]   = vrf_rd_data[port];
                        port               = port + 1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            port_data_vs1[i] = src_data[i][dispatch_pkg::class_vs1_bit];
            port_data_vs2[i] = src_data[i][dispatch_pkg::class_vs2_bit];
            port_data_vd[i]  = src_data[i][dispatch_pkg::class_vd_bit];
        end
    end

endmodule

//--- dispatch_ctrl.sv
/*
    Issue decision and handshakes for the two slots. A slot issues when it
    is free of hazards and both the reservation station and the ROB take
    it. Slot 1 only goes together with slot 0, so order is kept.
*/
`timescale 1ns/100ps

module dispatch_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [dispatch_pkg::num_dp_uop-1:0] uop_valid,
    input  logic [dispatch_pkg::num_dp_uop-1:0] raw_rob_hazard,
    input  logic                                raw_uop_hazard,
    input  logic                                arch_hazard,
    input  logic [dispatch_pkg::num_dp_uop-1:0] rs_ready,
    input  logic [dispatch_pkg::num_dp_uop-1:0] rob_ready,
    output logic [dispatch_pkg::num_dp_uop-1:0] uop_ready,
    output logic [dispatch_pkg::num_dp_uop-1:0] rs_valid,
    output logic [dispatch_pkg::num_dp_uop-1:0] rob_valid
);

    logic [dispatch_pkg::num_dp_uop-1:0] eligible;
    logic [dispatch_pkg::num_dp_uop-1:0] issue;

    // Slot 0 only waits on ROB writers
    assign eligible[0] = uop_valid[0] && !raw_rob_hazard[0];
    assign issue[0]    = eligible[0] && rs_ready[0] && rob_ready[0];

    // Slot 1 also waits on slot 0, the port limit and slot 0 leaving
    assign eligible[1] = uop_valid[1] && !raw_rob_hazard[1] && !raw_uop_hazard &&
                         !arch_hazard && issue[0];
    assign issue[1]    = eligible[1] && rs_ready[1] && rob_ready[1];

    assign uop_ready = issue;
    // Each side only sees a request when the other side can take it too
    assign rs_valid  = eligible & rob_ready;
    assign rob_valid = eligible & rs_ready;

    assert property (@(posedge clk) disable iff (reset) uop_ready[1] |-> uop_ready[0])
        else $error("slot 1 issued without slot 0");

    assert property (@(posedge clk) disable iff (reset)
                     ((rs_valid | rob_valid) & ~uop_valid) == '0)
        else $error("request on a slot with no valid uop");

endmodule

//--- vector_dispatch.sv
/*
    Two-slot vector dispatch stage. Takes up to two uops per cycle from the
    uop queue, checks RAW and read-port hazards, reads the VRF or bypasses
    from finished ROB entries, and hands issued uops to the arithmetic
    reservation station and the ROB. Purely combinational; clk and reset
    only qualify the checks in the control block.
*/
`timescale 1ns/100ps

module vector_dispatch (
    input  logic                                                                        clk,
    input  logic                                                                        reset,
    // Uop queue
    input  logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_valid,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::uop_class_width-1:0]     uop_class,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs1_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs2_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vd_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_vd_write,
    input  logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::funct_width-1:0]         uop_funct,
    output logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_ready,
    // Arithmetic reservation station
    output logic [dispatch_pkg::num_dp_uop-1:0]                                         rs_valid,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::rob_depth_width-1:0]     rs_rob_entry,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::funct_width-1:0]         rs_funct,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vs1_data,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vs2_data,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vd_data,
    input  logic [dispatch_pkg::num_dp_uop-1:0]                                         rs_ready,
    // ROB
    output logic [dispatch_pkg::num_dp_uop-1:0]                                         rob_valid,
    output logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] rob_w_index,
    input  logic [dispatch_pkg::num_dp_uop-1:0]                                         rob_ready,
    input  logic [dispatch_pkg::rob_depth_width-1:0]                                    rob_tail_index,
    input  logic [dispatch_pkg::rob_depth_width-1:0]                                    rob_head_index,
    input  logic [dispatch_pkg::rob_depth-1:0]                                          rob_entry_valid,
    input  logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::regfile_index_width-1:0]  rob_entry_w_index,
    input  logic [dispatch_pkg::rob_depth-1:0]                                          rob_entry_done,
    input  logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::vlen-1:0]                 rob_entry_data,
    // VRF data returns in the same cycle
    output logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::regfile_index_width-1:0] vrf_rd_index,
    input  logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::vlen-1:0]               vrf_rd_data
);

    logic [dispatch_pkg::num_dp_uop-1:0]                                  raw_rob_hazard;
    logic [dispatch_pkg::num_dp_uop-1:0][2:0]                             byp_hit;
    logic [dispatch_pkg::num_dp_uop-1:0][2:0][dispatch_pkg::rob_depth_width-1:0] byp_entry;
    logic                                                                 raw_uop_hazard;
    logic                                                                 arch_hazard;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]         port_data_vs1;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]         port_data_vs2;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]         port_data_vd;

    genvar i;

    generate
        for (i = 0; i < dispatch_pkg::num_dp_uop; i++) begin : gen_slot
            dispatch_raw_rob u_raw_rob (
                .uop_class         (uop_class[i]),
                .uop_vs1_index     (uop_vs1_index[i]),
                .uop_vs2_index     (uop_vs2_index[i]),
                .uop_vd_index      (uop_vd_index[i]),
                .rob_head_index    (rob_head_index),
                .rob_entry_valid   (rob_entry_valid),
                .rob_entry_w_index (rob_entry_w_index),
                .rob_entry_done    (rob_entry_done),
                .raw_hazard        (raw_rob_hazard[i]),
                .byp_hit           (byp_hit[i]),
                .byp_entry         (byp_entry[i])
            );

            dispatch_bypass u_bypass (
                .byp_hit        (byp_hit[i]),
                .byp_entry      (byp_entry[i]),
                .rob_entry_data (rob_entry_data),
                .port_data_vs1  (port_data_vs1[i]),
                .port_data_vs2  (port_data_vs2[i]),
                .port_data_vd   (port_data_vd[i]),
                .opr_vs1        (rs_vs1_data[i]),
                .opr_vs2        (rs_vs2_data[i]),
                .opr_vd         (rs_vd_data[i])
            );
        end
    endgenerate

    dispatch_raw_uop u_raw_uop (
        .uop0_valid     (uop_valid[0]),
        .uop0_vd_write  (uop_vd_write[0]),
        .uop0_vd_index  (uop_vd_index[0]),
        .uop1_class     (uop_class[1]),
        .uop1_vs1_index (uop_vs1_index[1]),
        .uop1_vs2_index (uop_vs2_index[1]),
        .uop1_vd_index  (uop_vd_index[1]),
        .raw_hazard     (raw_uop_hazard)
    );

    dispatch_read_port u_read_port (
        .uop_class     (uop_class),
        .uop_vs1_index (uop_vs1_index),
        .uop_vs2_index (uop_vs2_index),
        .uop_vd_index  (uop_vd_index),
        .vrf_rd_data   (vrf_rd_data),
        .vrf_rd_index  (vrf_rd_index),
        .arch_hazard   (arch_hazard),
        .port_data_vs1 (port_data_vs1),
        .port_data_vs2 (port_data_vs2),
        .port_data_vd  (port_data_vd)
    );

    dispatch_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .uop_valid      (uop_valid),
        .raw_rob_hazard (raw_rob_hazard),
        .raw_uop_hazard (raw_uop_hazard),
        .arch_hazard    (arch_hazard),
        .rs_ready       (rs_ready),
        .rob_ready      (rob_ready),
        .uop_ready      (uop_ready),
        .rs_valid       (rs_valid),
        .rob_valid      (rob_valid)
    );

    // Slot 1 takes the entry after the tail, wrapping with the ROB
    assign rs_rob_entry[0] = rob_tail_index;
    assign rs_rob_entry[1] = rob_tail_index + 1'b1;

    assign rs_funct    = uop_funct;
    assign rob_w_index = uop_vd_index;

endmodule

//--- tb_vector_dispatch.sv
/*
    Self-checking testbench for the vector dispatch stage. Cases come from
    dispatch_cases.txt: R lines load ROB entries, C lines drive both uop
    slots and give the expected handshakes. Inputs change on the falling
    edge and results are checked before the next rising edge.
*/
`timescale 1ns/100ps

module tb_vector_dispatch;

    localparam int clk_period    = 8;
    localparam int reset_cycles  = 4;
    localparam int reset_timeout = 20;
    localparam int max_lines     = 1000;

    logic                                                                        clk;
    logic                                                                        reset;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_valid;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::uop_class_width-1:0]     uop_class;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs1_index;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vs2_index;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] uop_vd_index;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_vd_write;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::funct_width-1:0]         uop_funct;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         uop_ready;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         rs_valid;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::rob_depth_width-1:0]     rs_rob_entry;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::funct_width-1:0]         rs_funct;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vs1_data;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vs2_data;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::vlen-1:0]                rs_vd_data;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         rs_ready;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         rob_valid;
    logic [dispatch_pkg::num_dp_uop-1:0][dispatch_pkg::regfile_index_width-1:0] rob_w_index;
    logic [dispatch_pkg::num_dp_uop-1:0]                                         rob_ready;
    logic [dispatch_pkg::rob_depth_width-1:0]                                    rob_tail_index;
    logic [dispatch_pkg::rob_depth_width-1:0]                                    rob_head_index;
    logic [dispatch_pkg::rob_depth-1:0]                                          rob_entry_valid;
    logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::regfile_index_width-1:0]  rob_entry_w_index;
    logic [dispatch_pkg::rob_depth-1:0]                                          rob_entry_done;
    logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::vlen-1:0]                 rob_entry_data;
    logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::regfile_index_width-1:0] vrf_rd_index;
    logic [dispatch_pkg::num_rd_port-1:0][dispatch_pkg::vlen-1:0]               vrf_rd_data;

    // ROB contents collected from R lines, applied with the next C line
    logic [dispatch_pkg::rob_depth-1:0]                                          m_valid;
    logic [dispatch_pkg::rob_depth-1:0]                                          m_done;
    logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::regfile_index_width-1:0]  m_w_index;
    logic [dispatch_pkg::rob_depth-1:0][dispatch_pkg::vlen-1:0]                 m_data;
    int fld [18];
    int seed;

    vector_dispatch i_vector_dispatch (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    initial begin
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
    end

    function automatic logic [dispatch_pkg::vlen-1:0] vrf_pattern(input logic [4:0] index);
        logic [7:0] fill;
        fill = {3'b000, index} + 8'd1;
        return {(dispatch_pkg::vlen / 8){fill}};
    endfunction

    // VRF answers in the same cycle
    always_comb begin
        for (int p = 0; p < dispatch_pkg::num_rd_port; p++) begin
            vrf_rd_data[p] = vrf_pattern(vrf_rd_index[p]);
        end
    end

    // Youngest ROB writer wins if done, otherwise the register file value
    function automatic logic [dispatch_pkg::vlen-1:0] expected_operand(input int head,
                                                                        input logic [4:0] index);
        int entry;
        int writer;
        writer = -1;
        for (int k = 0; k < dispatch_pkg::rob_depth; k++) begin
            entry = (head + k) % dispatch_pkg::rob_depth;
            if (m_valid[entry] && m_w_index[entry] == index)
                writer = entry;
        end
        if (writer >= 0 && m_done[writer])
            return m_data[writer];
        return vrf_pattern(index);
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected)
            else stop_with_failure($sformatf("ERR time %0t %s expected %h got %h",
                                             $time, name, expected, actual));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset) begin
            if (cycles == reset_timeout)
                stop_with_failure("reset was not released within the timeout");
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic run_case();
        logic [4:0] exp_index [4];
        logic [4:0] src_index [3];
        int         src_bit [3];
        int         total;
        int         port;
        @(negedge clk);
        rob_head_index    = fld[0];
        rob_tail_index    = fld[1];
        uop_valid         = fld[2];
        rs_ready          = fld[3];
        rob_ready         = fld[4];
        rob_entry_valid   = m_valid;
        rob_entry_done    = m_done;
        rob_entry_w_index = m_w_index;
        rob_entry_data    = m_data;
        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            uop_class[i]     = fld[8 + 5 * i];
            uop_vs1_index[i] = fld[9 + 5 * i];
            uop_vs2_index[i] = fld[10 + 5 * i];
            uop_vd_index[i]  = fld[11 + 5 * i];
            uop_vd_write[i]  = fld[12 + 5 * i];
            uop_funct[i]     = $random(seed);
        end
        #(clk_period / 4);
        check_value("uop_ready", uop_ready, fld[5]);
        check_value("rs_valid", rs_valid, fld[6]);
        check_value("rob_valid", rob_valid, fld[7]);

        // Ports go out in vs2, vs1, vd order, slot 1 only when all fit
        src_bit   = '{dispatch_pkg::class_vs2_bit, dispatch_pkg::class_vs1_bit,
                      dispatch_pkg::class_vd_bit};
        exp_index = '{default: '0};
        total     = $countones(uop_class[0]) + $countones(uop_class[1]);
        port      = 0;
        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            src_index = '{uop_vs2_index[i], uop_vs1_index[i], uop_vd_index[i]};
            if (i == 0 || total <= dispatch_pkg::num_rd_port) begin
                for (int k = 0; k < 3; k++) begin
                    if (uop_class[i][src_bit[k]]) begin
                        exp_index[port] = src_index[k];
                        port++;
                    end
                end
            end
        end
        for (int p = 0; p < dispatch_pkg::num_rd_port; p++)
            check_value($sformatf("vrf_rd_index[%0d]", p), vrf_rd_index[p], exp_index[p]);

        for (int i = 0; i < dispatch_pkg::num_dp_uop; i++) begin
            if (uop_ready[i]) begin
                check_value($sformatf("rs_rob_entry[%0d]", i), rs_rob_entry[i],
                            (fld[1] + i) % dispatch_pkg::rob_depth);
                check_value($sformatf("rs_funct[%0d]", i), rs_funct[i], uop_funct[i]);
                check_value($sformatf("rob_w_index[%0d]", i), rob_w_index[i], uop_vd_index[i]);
                if (uop_class[i][dispatch_pkg::class_vs1_bit])
                    check_value($sformatf("rs_vs1_data[%0d]", i), rs_vs1_data[i],
                                expected_operand(fld[0], uop_vs1_index[i]));
                if (uop_class[i][dispatch_pkg::class_vs2_bit])
                    check_value($sformatf("rs_vs2_data[%0d]", i), rs_vs2_data[i],
                                expected_operand(fld[0], uop_vs2_index[i]));
                if (uop_class[i][dispatch_pkg::class_vd_bit])
                    check_value($sformatf("rs_vd_data[%0d]", i), rs_vd_data[i],
                                expected_operand(fld[0], uop_vd_index[i]));
            end
        end
    endtask

    initial begin
        string      line;
        int         fd;
        int         count;
        int         lines_read;
        int         cases_run;
        int         entry;
        int         w_index;
        int         done;
        logic [7:0] fill;
        seed = 32'hd7cab72b;
        reset = 1'b1;
        uop_valid = '0;
        uop_class = '0;
        uop_vs1_index = '0;
        uop_vs2_index = '0;
        uop_vd_index = '0;
        uop_vd_write = '0;
        uop_funct = '0;
        rs_ready = '0;
        rob_ready = '0;
        rob_tail_index = '0;
        rob_head_index = '0;
        rob_entry_valid = '0;
        rob_entry_w_index = '0;
        rob_entry_done = '0;
        rob_entry_data = '0;
        m_valid = '0;
        m_done = '0;
        m_w_index = '0;
        m_data = '0;
        lines_read = 0;
        cases_run = 0;

        wait_reset_release();
        check_value("uop_ready", uop_ready, 0);
        check_value("rs_valid", rs_valid, 0);
        check_value("rob_valid", rob_valid, 0);

        fd = $fopen("dispatch_cases.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open dispatch_cases.txt");
        while (!$feof(fd) && lines_read < max_lines) begin
            line = "";
            count = $fgets(line, fd);
            lines_read++;
            if (count > 0 && line.getc(0) == "R") begin
                count = $sscanf(line, "R %h %h %h %h", entry, w_index, done, fill);
                if (count != 4)
                    stop_with_failure($sformatf("bad ROB line %0d in case file", lines_read));
                m_valid[entry]   = 1'b1;
                m_done[entry]    = done;
                m_w_index[entry] = w_index;
                m_data[entry]    = {(dispatch_pkg::vlen / 8){fill}};
            end else if (count > 0 && line.getc(0) == "C") begin
                count = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                                fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                                fld[15], fld[16], fld[17]);
                if (count != 18)
                    stop_with_failure($sformatf("bad case line %0d in case file", lines_read));
                run_case();
                cases_run++;
                m_valid = '0;
                m_done  = '0;
            end
        end
        $fclose(fd);

        if (cases_run == 0) begin
            stop_with_failure("the case file held no cases");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- dispatch_cases.txt
# R entry w_index done fill : a valid ROB entry, data is the fill byte repeated
# C head tail uop_valid rs_ready rob_ready exp_uop_ready exp_rs_valid exp_rob_valid
#   then per slot, slot 0 first: class vs1 vs2 vd vd_write (class bits: vd, vs2, vs1)
C 0 3 3 3 3 3 3 3  3 01 02 03 1  3 04 05 06 1
C 0 7 3 3 3 3 3 3  7 0a 0b 0c 1  1 0d 00 0e 1
R 2 05 0 55
C 0 3 3 3 3 1 1 1  3 01 02 03 1  1 05 00 06 1
R 1 01 0 44
C 0 3 3 3 3 0 0 0  1 01 00 03 1  2 00 07 08 1
R 6 08 1 66
R 1 08 0 11
C 6 2 1 3 3 0 0 0  2 00 08 09 1  0 00 00 00 0
R 0 09 1 aa
R 3 09 1 bb
C 0 4 3 3 3 3 3 3  1 09 00 0a 1  2 00 09 0b 1
R 6 0c 0 cc
R 2 0c 1 dd
C 5 3 3 3 3 3 3 3  4 00 00 0c 1  5 0e 00 0f 1
C 0 0 3 3 3 1 1 1  3 01 02 10 1  2 00 10 11 1
C 0 0 3 3 3 3 3 3  3 01 02 10 0  2 00 10 11 1
C 0 0 3 3 3 1 1 1  7 11 12 13 1  3 14 15 16 1
C 0 0 3 2 3 0 1 0  3 01 02 03 1  3 04 05 06 1
C 0 0 3 3 2 0 0 1  3 01 02 03 1  3 04 05 06 1
C 0 0 3 0 0 0 0 0  3 01 02 03 1  3 04 05 06 1
C 0 0 3 1 3 1 3 1  3 01 02 03 1  3 04 05 06 1
C 0 0 2 3 3 0 0 0  3 01 02 03 1  3 04 05 06 1
C 0 0 0 3 3 0 0 0  3 01 02 03 1  3 04 05 06 1

//--- vlog.f
dispatch_pkg.sv
dispatch_raw_rob.sv
dispatch_bypass.sv
dispatch_raw_uop.sv
dispatch_read_port.sv
dispatch_ctrl.sv
vector_dispatch.sv
tb_vector_dispatch.sv
